/* Makefile */
# Verilator build and run of the MCU bring-up testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '** FAIL **' $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ] || ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation ended abnormally, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/exec_stage.sv */
// reduced rv32i subset, unsupported encodings retire as nop, word-only lw/sw
`timescale 1ns/1ps

module exec_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mcu_pkg::fetch_pkt_t pkt_i,
    output logic                ready_o,
    output mcu_pkg::redirect_t  redirect_o,
    output mcu_pkg::data_req_t  data_req_o,
    input  mcu_pkg::data_rsp_t  data_rsp_i
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

    state_e               state_q;
    mcu_pkg::instr_word_u ir;
    logic [31:0]          rs1_val;
    logic [31:0]          rs2_val;
    logic [31:0]          imm_i;
    logic [31:0]          imm_s;
    logic [31:0]          imm_b;
    logic [31:0]          imm_j;
    logic [31:0]          imm_u;
    logic                 accept;
    logic                 alu_we;
    logic [31:0]          alu_res;
    logic                 take;
    logic [31:0]          target;
    logic                 is_lw;
    logic                 is_sw;
    logic                 mem_we_q;
    logic [31:0]          mem_addr_q;
    logic [31:0]          mem_wdata_q;
    logic [4:0]           mem_rd_q;
    logic                 load_done;

    assign ir     = pkt_i.instr;
    assign accept = pkt_i.valid && ready_o;

    // immediates from the two views
    assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
    assign imm_b = {{20{ir.s.imm_hi[6]}}, ir.s.imm_lo[0], ir.s.imm_hi[5:0],
                    ir.s.imm_lo[4:1], 1'b0};
    // J layout sits in the I view upper bits
    assign imm_j = {{12{ir.i.imm[11]}}, ir.i.rs1, ir.i.funct3, ir.i.imm[0],
                    ir.i.imm[10:1], 1'b0};
    assign imm_u = {ir.s.imm_hi, ir.s.rs2, ir.s.rs1, ir.s.funct3, 12'd0};

    regfile regfile_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (ir.i.rs1),
        .raddr_b_i (ir.s.rs2),
        .rdata_a_o (rs1_val),
        .rdata_b_o (rs2_val),
        .we_i      ((accept && alu_we) || load_done),
        .waddr_i   (load_done ? mem_rd_q : ir.i.rd),
        .wdata_i   (load_done ? data_rsp_i.rdata : alu_res)
    );

    // decode and alu
    always_comb begin
        alu_we  = 1'b0;
        alu_res = 32'd0;
        take    = 1'b0;
        target  = pkt_i.pc + imm_b;
        is_lw   = 1'b0;
        is_sw   = 1'b0;
        case (ir.i.opcode)
            mcu_pkg::OPC_LUI: begin
                alu_we  = 1'b1;
                alu_res = imm_u;
            end
            mcu_pkg::OPC_OP_IMM: begin
                alu_we  = (ir.i.funct3 == 3'b000);
                alu_res = rs1_val + imm_i;
            end
            mcu_pkg::OPC_OP: begin
                // funct7 lives in imm[11:5]
                alu_we  = (ir.i.funct3 == 3'b000) && (ir.i.imm[11:5] == 7'b0000000 ||
                                                      ir.i.imm[11:5] == 7'b0100000);
                alu_res = ir.i.imm[10] ? rs1_val - rs2_val : rs1_val + rs2_val;
            end
            mcu_pkg::OPC_LOAD:  is_lw = (ir.i.funct3 == 3'b010);
            mcu_pkg::OPC_STORE: is_sw = (ir.s.funct3 == 3'b010);
            mcu_pkg::OPC_BRANCH: begin
                // beq and bne only
                if (ir.s.funct3 == 3'b000) begin
                    take = (rs1_val == rs2_val);
                end else if (ir.s.funct3 == 3'b001) begin
                    take = (rs1_val != rs2_val);
                end
            end
            mcu_pkg::OPC_JAL: begin
                alu_we  = 1'b1;
                alu_res = pkt_i.pc + 32'd4;
                take    = 1'b1;
                target  = pkt_i.pc + imm_j;
            end
            default: ;
        endcase
    end

    assign redirect_o.valid  = accept && take;
    assign redirect_o.target = target;

    // busy while a memory access is open
    assign ready_o   = (state_q == ST_IDLE);
    assign load_done = (state_q == ST_WAIT) && data_rsp_i.rvalid && !mem_we_q;

    assign data_req_o.req   = (state_q == ST_REQ);
    assign data_req_o.we    = mem_we_q;
    assign data_req_o.be    = 4'b1111;
    assign data_req_o.addr  = mem_addr_q;
    assign data_req_o.wdata = mem_wdata_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (accept && (is_lw || is_sw)) state_q <= ST_REQ;
                ST_REQ:  if (data_rsp_i.gnt) state_q <= ST_WAIT;
                ST_WAIT: if (data_rsp_i.rvalid) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // access captured at accept time
    always_ff @(posedge clk_i) begin
        if (accept && (is_lw || is_sw)) begin
            mem_we_q    <= is_sw;
            mem_addr_q  <= rs1_val + (is_sw ? imm_s : imm_i);
            mem_wdata_q <= rs2_val;
            mem_rd_q    <= ir.i.rd;
        end
    end

endmodule

/* hdl/fetch_stage.sv */
// assumes the memory grants in the request cycle and answers exactly one cycle later
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                fetch_enable_i,
    output mcu_pkg::instr_req_t instr_req_o,
    input  mcu_pkg::instr_rsp_t instr_rsp_i,
    output mcu_pkg::fetch_pkt_t pkt_o,
    input  logic                ready_i,
    input  mcu_pkg::redirect_t  redirect_i
);

    logic [31:0]          pc_q;
    logic [31:0]          out_pc_q;
    logic                 outstanding_q;
    logic                 discard_q;
    logic                 slot_valid_q;
    logic [31:0]          slot_pc_q;
    mcu_pkg::instr_word_u slot_instr_q;
    logic                 resp_ok;
    logic                 hold;
    logic                 granted;

    // response that survived any redirect
    assign resp_ok = instr_rsp_i.rvalid && !discard_q;

    // slot first, else bypass the arriving word
    always_comb begin
        if (slot_valid_q) begin
            pkt_o.valid = 1'b1;
            pkt_o.pc    = slot_pc_q;
            pkt_o.instr = slot_instr_q;
        end else begin
            pkt_o.valid = resp_ok;
            pkt_o.pc    = out_pc_q;
            pkt_o.instr = instr_rsp_i.rdata;
        end
    end

    // packet not taken this cycle, so it parks in the slot
    assign hold = pkt_o.valid && !ready_i && !redirect_i.valid;

    // no room for another word while the slot stays busy
    assign instr_req_o.req  = fetch_enable_i && !hold &&
                              (!outstanding_q || instr_rsp_i.rvalid);
    assign instr_req_o.addr = pc_q;
    assign granted          = instr_req_o.req && instr_rsp_i.gnt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= mcu_pkg::BOOT_ADDR;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
            slot_valid_q  <= 1'b0;
        end else begin
            slot_valid_q <= hold;
            // a word requested during a redirect belongs to the old path
            if (granted) begin
                outstanding_q <= 1'b1;
                discard_q     <= redirect_i.valid;
            end else if (instr_rsp_i.rvalid) begin
                outstanding_q <= 1'b0;
                discard_q     <= 1'b0;
            end
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (granted) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // payload only
    always_ff @(posedge clk_i) begin
        if (granted) begin
            out_pc_q <= pc_q;
        end
        if (hold) begin
            slot_pc_q    <= pkt_o.pc;
            slot_instr_q <= pkt_o.instr;
        end
    end

endmodule

/* hdl/mcu_pkg.sv */
// word-only buses, peripheral window decoded on the low 64 KiB above PERIPH_BASE
package mcu_pkg;

    // memory map
    localparam int unsigned RAM_ADDR_WIDTH   = 16;
    localparam int unsigned RAM_WORDS        = 2 ** (RAM_ADDR_WIDTH - 2);
    localparam logic [31:0] BOOT_ADDR        = 32'h0000_0080;
    localparam logic [31:0] PERIPH_BASE      = 32'h2000_0000;
    localparam logic [31:0] TEST_STATUS_ADDR = PERIPH_BASE + 32'd0;
    localparam logic [31:0] EXIT_VALUE_ADDR  = PERIPH_BASE + 32'd4;
    localparam logic [31:0] TEST_PASS_MAGIC  = 32'd123456789;

    // rv32i major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // request/grant/rvalid ports
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } instr_rsp_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } data_rsp_t;

    // I view, also used for U and J immediates
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S view, B immediate rebuilt from the same fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i;
        s_fmt_t s;
    } instr_word_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_word_u instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

/* hdl/mcu_tb_wrapper.sv */
// bring-up top, results visible only through the pseudo-peripheral outputs
`timescale 1ns/1ps

module mcu_tb_wrapper (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        fetch_enable_i,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o
);

    // core to memory
    mcu_pkg::instr_req_t instr_req;
    mcu_pkg::instr_rsp_t instr_rsp;
    mcu_pkg::data_req_t  data_req;
    mcu_pkg::data_rsp_t  data_rsp;

    // fetch to execute
    mcu_pkg::fetch_pkt_t fetch_pkt;
    logic                exec_ready;
    mcu_pkg::redirect_t  redirect;

    fetch_stage fetch_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_rsp_i    (instr_rsp),
        .pkt_o          (fetch_pkt),
        .ready_i        (exec_ready),
        .redirect_i     (redirect)
    );

    exec_stage exec_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .pkt_i      (fetch_pkt),
        .ready_o    (exec_ready),
        .redirect_o (redirect),
        .data_req_o (data_req),
        .data_rsp_i (data_rsp)
    );

    // RAM plus pass/fail/exit registers
    mm_ram ram_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req),
        .instr_rsp_o    (instr_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

/* hdl/mm_ram.sv */
// simulation RAM aliased over the low address bits, program loaded by the testbench
`timescale 1ns/1ps

module mm_ram (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mcu_pkg::instr_req_t instr_req_i,
    output mcu_pkg::instr_rsp_t instr_rsp_o,
    input  mcu_pkg::data_req_t  data_req_i,
    output mcu_pkg::data_rsp_t  data_rsp_o,
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output logic [31:0]         exit_value_o
);

    logic [31:0]                         mem [mcu_pkg::RAM_WORDS];
    logic [mcu_pkg::RAM_ADDR_WIDTH-3:0] instr_idx;
    logic [mcu_pkg::RAM_ADDR_WIDTH-3:0] data_idx;
    logic                                instr_rvalid_q;
    logic [31:0]                         instr_rdata_q;
    logic                                data_rvalid_q;
    logic [31:0]                         data_rdata_q;
    logic                                periph_sel;
    logic                                periph_wr;
    logic                                passed_q;
    logic                                failed_q;
    logic                                exit_valid_q;
    logic [31:0]                         exit_value_q;

    // word index from the low byte-address bits
    assign instr_idx = instr_req_i.addr[mcu_pkg::RAM_ADDR_WIDTH-1:2];
    assign data_idx  = data_req_i.addr[mcu_pkg::RAM_ADDR_WIDTH-1:2];

    // 64 KiB window at the peripheral base
    assign periph_sel = (data_req_i.addr[31:mcu_pkg::RAM_ADDR_WIDTH] ==
                         mcu_pkg::PERIPH_BASE[31:mcu_pkg::RAM_ADDR_WIDTH]);
    assign periph_wr  = data_req_i.req && data_req_i.we && periph_sel;

    // both ports always grant at once
    assign instr_rsp_o.gnt    = instr_req_i.req;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_rdata_q;

    assign data_rsp_o.gnt     = data_req_i.req;
    assign data_rsp_o.rvalid  = data_rvalid_q;
    assign data_rsp_o.rdata   = data_rdata_q;

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

    // rvalid one cycle after each grant, writes included
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i.req;
            data_rvalid_q  <= data_req_i.req;
        end
    end

    // array access, no reset on storage
    always_ff @(posedge clk_i) begin
        if (instr_req_i.req) begin
            instr_rdata_q <= mem[instr_idx];
        end
        if (data_req_i.req) begin
            if (data_req_i.we) begin
                data_rdata_q <= 32'd0;
                if (!periph_sel) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_req_i.be[b]) begin
                            mem[data_idx][8*b +: 8] <= data_req_i.wdata[8*b +: 8];
                        end
                    end
                end
            end else begin
                // peripherals read back as zero
                data_rdata_q <= periph_sel ? 32'd0 : mem[data_idx];
            end
        end
    end

    // sticky result flags
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
            exit_value_q <= 32'd0;
        end else if (periph_wr) begin
            if (data_req_i.addr == mcu_pkg::TEST_STATUS_ADDR) begin
                // anything but the magic word counts as fail
                if (data_req_i.wdata == mcu_pkg::TEST_PASS_MAGIC) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
            if (data_req_i.addr == mcu_pkg::EXIT_VALUE_ADDR) begin
                // later writes overwrite the value
                exit_valid_q <= 1'b1;
                exit_value_q <= data_req_i.wdata;
            end
        end
    end

endmodule

/* hdl/regfile.sv */
// two asynchronous read ports, one write port, x0 hardwired to zero
`timescale 1ns/1ps

module regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [1:31];

    // x0 never stored
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= 32'd0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

/* project.f */
hdl/mcu_pkg.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/exec_stage.sv
hdl/mm_ram.sv
hdl/mcu_tb_wrapper.sv
verif/mcu_checker.sv
verif/tb_top.sv

/* verif/mcu_checker.sv */
// bound into mcu_tb_wrapper, assumes single-cycle rvalid after every grant
`timescale 1ns/1ps

module mcu_checker (
    input logic                clk_i,
    input logic                arst_n_i,
    input mcu_pkg::instr_req_t instr_req_i,
    input mcu_pkg::instr_rsp_t instr_rsp_i,
    input mcu_pkg::data_req_t  data_req_i,
    input mcu_pkg::data_rsp_t  data_rsp_i,
    input logic                passed_i,
    input logic                failed_i,
    input logic                exit_valid_i
);

    // grant only for a live request
    instr_gnt_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_rsp_i.gnt |-> instr_req_i.req) else $error("instr gnt without req");
    data_gnt_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_rsp_i.gnt |-> data_req_i.req) else $error("data gnt without req");

    // rvalid one cycle after a grant
    instr_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_rsp_i.rvalid |-> $past(instr_rsp_i.gnt && instr_req_i.req))
        else $error("instr rvalid without grant");
    data_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_rsp_i.rvalid |-> $past(data_rsp_i.gnt && data_req_i.req))
        else $error("data rvalid without grant");

    // sticky until reset
    passed_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$fell(passed_i)) else $error("tests_passed_o fell");
    failed_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$fell(failed_i)) else $error("tests_failed_o fell");
    exit_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$fell(exit_valid_i)) else $error("exit_valid_o fell");

    pass_fail_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(passed_i && failed_i)) else $error("passed and failed both set");

endmodule

bind mcu_tb_wrapper mcu_checker checker_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .instr_req_i  (instr_req),
    .instr_rsp_i  (instr_rsp),
    .data_req_i   (data_req),
    .data_rsp_i   (data_rsp),
    .passed_i     (tests_passed_o),
    .failed_i     (tests_failed_o),
    .exit_valid_i (exit_valid_o)
);

/* verif/tb_top.sv */
// directed tests only, programs are loaded into the RAM array by hierarchical writes during reset
`timescale 1ns/1ps

module tb_top;

    // per-program cycle budget, six programs in total
    localparam int BUDGET_CYCLES = 2000;
    localparam int RUN_COUNT     = 6;

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        fetch_enable_i;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    logic [31:0] exit_value_o;

    logic [15:0] lfsr_q = 16'd40719;
    logic [31:0] prog [$];
    int          n_checks = 0;
    int          n_errors = 0;

    mcu_tb_wrapper UUT (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    // 8 ns period
    always #4 clk_i = ~clk_i;

    // galois lfsr, one step per bit
    function automatic logic lfsr_step();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // rv32i encoders
    function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // add or sub, picked by funct7
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, mcu_pkg::OPC_OP};
    endfunction

    // sw only
    function automatic logic [31:0] stype_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], mcu_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], mcu_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, mcu_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, mcu_pkg::OPC_JAL};
    endfunction

    // lui plus addi, upper part rounded for the sign-extended low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        prog.push_back(lui_word(rd, hi[19:0]));
        prog.push_back(itype_word(mcu_pkg::OPC_OP_IMM, rd, 3'b000, rd, value[11:0]));
    endtask

    // exit store then self loop, x7 holds the peripheral base
    task automatic report_exit(input logic [4:0] rs);
        prog.push_back(lui_word(5'd7, mcu_pkg::PERIPH_BASE[31:12]));
        prog.push_back(stype_word(rs, 5'd7,
                                  12'(mcu_pkg::EXIT_VALUE_ADDR - mcu_pkg::PERIPH_BASE)));
        prog.push_back(jal_word(5'd0, 21'd0));
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // reset, load, optional enable delay, then wait for the exit flag
    task automatic run_program(input int gate_cycles);
        logic seen_exit;
        int   base_word;
        seen_exit = 1'b0;
        base_word = int'(mcu_pkg::BOOT_ADDR >> 2);
        @(negedge clk_i);
        arst_n_i       = 1'b0;
        fetch_enable_i = 1'b0;
        foreach (prog[k]) begin
            UUT.ram_i.mem[base_word + k] = prog[k];
        end
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        repeat (gate_cycles) begin
            @(negedge clk_i);
            seen_exit = seen_exit | exit_valid_o;
        end
        if (gate_cycles > 0) begin
            check_flag("exit_valid_o while fetch disabled", seen_exit, 1'b0);
        end
        fetch_enable_i = 1'b1;
        while (!exit_valid_o) @(negedge clk_i);
    endtask

    task automatic arith_check(input int gate_cycles);
        logic [31:0] a;
        logic [31:0] b;
        logic [19:0] upper;
        logic [11:0] imm;
        logic [31:0] expected;
        logic [31:0] raw;
        a     = rand_bits(32);
        b     = rand_bits(32);
        raw   = rand_bits(20);
        upper = raw[19:0];
        raw   = rand_bits(12);
        imm   = raw[11:0];
        prog.delete();
        load_const(5'd1, a);
        load_const(5'd2, b);
        // x3 = a + b, x5 = x3 - (upper << 12), x6 = x5 + imm
        prog.push_back(rtype_word(7'b0000000, 5'd2, 5'd1, 5'd3));
        prog.push_back(lui_word(5'd4, upper));
        prog.push_back(rtype_word(7'b0100000, 5'd4, 5'd3, 5'd5));
        prog.push_back(itype_word(mcu_pkg::OPC_OP_IMM, 5'd6, 3'b000, 5'd5, imm));
        report_exit(5'd6);
        expected = a + b - {upper, 12'h000} + {{20{imm[11]}}, imm};
        run_program(gate_cycles);
        check_word("arithmetic exit value", exit_value_o, expected);
    endtask

    task automatic mem_round_trip();
        logic [31:0] v [4];
        logic [31:0] sum;
        int          order [4];
        order = '{2, 0, 3, 1};
        sum   = '0;
        prog.delete();
        // data block at 0x1000, clear of the program
        prog.push_back(lui_word(5'd8, 20'd1));
        for (int i = 0; i < 4; i++) begin
            v[i] = rand_bits(32);
            sum  = sum + v[i];
            load_const(5'(1 + i), v[i]);
            prog.push_back(stype_word(5'(1 + i), 5'd8, 12'(4 * i)));
        end
        // reload out of order through x5, accumulate in x11
        for (int i = 0; i < 4; i++) begin
            prog.push_back(itype_word(mcu_pkg::OPC_LOAD, 5'd5, 3'b010, 5'd8,
                                      12'(4 * order[i])));
            prog.push_back(rtype_word(7'b0000000, 5'd5, 5'd11, 5'd11));
        end
        report_exit(5'd11);
        run_program(0);
        check_word("memory round trip sum", exit_value_o, sum);
    endtask

    task automatic branch_loop();
        logic [31:0] n;
        n = rand_bits(5) + 32'd1;
        prog.delete();
        prog.push_back(itype_word(mcu_pkg::OPC_OP_IMM, 5'd1, 3'b000, 5'd0, n[11:0]));
        prog.push_back(rtype_word(7'b0000000, 5'd1, 5'd2, 5'd2));
        prog.push_back(itype_word(mcu_pkg::OPC_OP_IMM, 5'd1, 3'b000, 5'd1, 12'hfff));
        // bne back by two words
        prog.push_back(btype_word(3'b001, 5'd1, 5'd0, 13'h1ff8));
        // jump over the poison addi
        prog.push_back(jal_word(5'd0, 21'd8));
        prog.push_back(itype_word(mcu_pkg::OPC_OP_IMM, 5'd2, 3'b000, 5'd2, 12'd1));
        report_exit(5'd2);
        run_program(0);
        check_word("branch loop sum", exit_value_o, n * (n + 32'd1) / 32'd2);
    endtask

    task automatic status_flags();
        logic [31:0] value [2];
        logic        pass_exp;
        value[0] = mcu_pkg::TEST_PASS_MAGIC;
        value[1] = rand_bits(32);
        if (value[1] == mcu_pkg::TEST_PASS_MAGIC) begin
            value[1] = value[1] ^ 32'h1;
        end
        for (int p = 0; p < 2; p++) begin
            pass_exp = (value[p] == mcu_pkg::TEST_PASS_MAGIC);
            prog.delete();
            prog.push_back(lui_word(5'd7, mcu_pkg::PERIPH_BASE[31:12]));
            load_const(5'd1, value[p]);
            prog.push_back(stype_word(5'd1, 5'd7,
                                      12'(mcu_pkg::TEST_STATUS_ADDR - mcu_pkg::PERIPH_BASE)));
            report_exit(5'd1);
            run_program(0);
            check_word("status program exit value", exit_value_o, value[p]);
            // flags once at exit and again later, still set
            for (int r = 0; r < 2; r++) begin
                check_flag("tests_passed_o", tests_passed_o, pass_exp);
                check_flag("tests_failed_o", tests_failed_o, !pass_exp);
                repeat (30) @(negedge clk_i);
            end
        end
    endtask

    task automatic enable_gating();
        arith_check(200);
    endtask

    initial begin
        arst_n_i       = 1'b0;
        fetch_enable_i = 1'b0;
        arith_check(0);
        mem_round_trip();
        branch_loop();
        status_flags();
        enable_gating();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog over all programs
    initial begin
        repeat (RUN_COUNT * BUDGET_CYCLES) @(posedge clk_i);
        $display("run timed out after %0d cycles before all tests finished",
                 RUN_COUNT * BUDGET_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule
